/* Makefile */
SIM      = verilator
TOP      = tb_switch_top
FILELIST = all.f
OBJDIR   = obj_dir
SIMFLAGS = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* all.f */
+incdir+.
eth_types_pkg.sv
fabric_types_pkg.sv
rx_frame_buffer.sv
mac_address_table.sv
switch_fabric.sv
tx_port_fanout.sv
switch_top.sv
tb_switch_top.sv

/* eth_types_pkg.sv */
`include "switch_params.svh"

package eth_types_pkg;

	// Ethernet field types
	typedef logic [47:0] macaddr_t;
	typedef logic [7:0] byte_t;

	// Port index and one-hot or flood egress mask
	typedef logic [`PORT_BITS-1:0] port_t;
	typedef logic [`NUM_PORTS-1:0] portmask_t;

	// One received byte of a port
	// sof and eof are only meaningful with valid high
	typedef struct packed {
		logic valid;
		logic sof;
		logic eof;
		byte_t data;
	} rx_stream_t;

endpackage

/* fabric_types_pkg.sv */
package fabric_types_pkg;

	import eth_types_pkg::*;

	// Frame length in bytes, wide enough for oversize detection
	typedef logic [6:0] frame_len_t;

	// Per port sent frame counter
	typedef logic [15:0] frame_count_t;

	// Header of a stored frame
	typedef struct packed {
		macaddr_t dst;
		macaddr_t src;
		frame_len_t len;
	} frame_hdr_t;

	// Combined learn and lookup request
	typedef struct packed {
		logic en;
		macaddr_t src_mac;
		port_t src_port;
		macaddr_t dst_mac;
	} lookup_req_t;

	// Lookup result, one cycle after the request
	typedef struct packed {
		logic hit;
		port_t dst_port;
	} lookup_resp_t;

	// Byte stream from fabric to output side
	// Mask is constant for a whole frame
	typedef struct packed {
		logic valid;
		logic sof;
		logic eof;
		byte_t data;
		portmask_t mask;
	} egress_stream_t;

endpackage

/* mac_address_table.sv */
`timescale 1ns/1ps
`include "switch_params.svh"

module mac_address_table import eth_types_pkg::*, fabric_types_pkg::*; (
	input  logic         clk_fabric,
	input  logic         arst_n,
	input  lookup_req_t  req,
	output lookup_resp_t resp
);

	localparam int ENTRIES = 1 << `MAC_TABLE_BITS;

	// Index is the low bits of the address
	typedef logic [`MAC_TABLE_BITS-1:0] tbl_idx_t;

	// Stored address and the port it was seen on
	typedef struct packed {
		macaddr_t mac;
		port_t port;
	} tbl_entry_t;

	////////////////////////////////////////////////////////////
	// Table storage

	logic [ENTRIES-1:0] entry_valid;
	tbl_entry_t         entries [ENTRIES];

	tbl_idx_t           dst_idx;
	tbl_idx_t           src_idx;
	tbl_entry_t         dst_entry;

	// Registered response fields
	logic               hit_q;
	port_t              port_q;

	assign dst_idx   = req.dst_mac[`MAC_TABLE_BITS-1:0];
	assign src_idx   = req.src_mac[`MAC_TABLE_BITS-1:0];
	assign dst_entry = entries[dst_idx];

	////////////////////////////////////////////////////////////
	// Lookup and learn

	// Valid bits and hit flag
	always_ff @(posedge clk_fabric or negedge arst_n) begin
		if (!arst_n) begin
			entry_valid <= '0;
			hit_q       <= 1'b0;
		end else begin
			// Hit only when slot is live and full address matches
			hit_q <= req.en && entry_valid[dst_idx] &&
				(dst_entry.mac == req.dst_mac);
			if (req.en)
				entry_valid[src_idx] <= 1'b1;
		end
	end

	// Entry contents and looked up port
	always_ff @(posedge clk_fabric) begin
		if (req.en) begin
			port_q <= dst_entry.port;
			// Same edge as the read, so a self lookup sees old contents
			// Colliding source simply evicts the older address
			entries[src_idx] <= '{mac: req.src_mac, port: req.src_port};
		end
	end

	assign resp = '{hit: hit_q, dst_port: port_q};

endmodule

/* rx_frame_buffer.sv */
`timescale 1ns/1ps
`include "switch_params.svh"

module rx_frame_buffer import eth_types_pkg::*, fabric_types_pkg::*; (
	input  logic       clk_fabric,
	input  logic       arst_n,
	input  rx_stream_t rx,
	input  logic       pop,
	output logic       frame_ready,
	output frame_hdr_t hdr,
	output byte_t      pop_data
);

	localparam int ADDR_BITS = $clog2(`FRAME_BUF_BYTES);
	localparam int HDR_BYTES = 12;

	// Frame storage
	byte_t       mem [`FRAME_BUF_BYTES];
	// Dst and src bytes with the first byte on top
	logic [95:0] hdr_sr;

	// Write side state
	logic        rx_active;
	frame_len_t  wr_cnt;
	// Read side state
	frame_len_t  rd_ptr;

	frame_len_t  byte_idx;
	logic        idx_in_buf;
	logic        take;
	logic        commit;

	////////////////////////////////////////////////////////////
	// Write side decode

	always_comb begin
		// New frame only starts when the buffer is free
		take       = rx.valid && (rx.sof ? !frame_ready : rx_active);
		byte_idx   = rx.sof ? '0 : wr_cnt;
		// Stays low for the rest of the frame once the count saturates
		idx_in_buf = byte_idx < frame_len_t'(`FRAME_BUF_BYTES);
		// Keep only complete frames of legal length
		commit     = take && rx.eof && !frame_ready && idx_in_buf &&
			(byte_idx + 1'b1 >= frame_len_t'(`MIN_FRAME_BYTES));
	end

	////////////////////////////////////////////////////////////
	// Data path

	always_ff @(posedge clk_fabric) begin
		if (take && idx_in_buf)
			mem[byte_idx[ADDR_BITS-1:0]] <= rx.data;
		// Header bytes shift in during the first 12 bytes
		if (take && byte_idx < frame_len_t'(HDR_BYTES))
			hdr_sr <= {hdr_sr[87:0], rx.data};
		// Publish header with the frame
		if (commit) begin
			hdr.dst <= hdr_sr[95:48];
			hdr.src <= hdr_sr[47:0];
			hdr.len <= byte_idx + 1'b1;
		end
		// Read data one cycle after the pop
		if (pop)
			pop_data <= mem[rd_ptr[ADDR_BITS-1:0]];
	end

	////////////////////////////////////////////////////////////
	// Control

	always_ff @(posedge clk_fabric or negedge arst_n) begin
		if (!arst_n) begin
			rx_active   <= 1'b0;
			wr_cnt      <= '0;
			rd_ptr      <= '0;
			frame_ready <= 1'b0;
		end else begin
			if (take) begin
				rx_active <= !rx.eof;
				// Counter saturates at buffer size
				wr_cnt    <= idx_in_buf ? byte_idx + 1'b1 : byte_idx;
			end
			if (commit)
				frame_ready <= 1'b1;
			else if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				// Last byte popped so the buffer is free next cycle
				if (rd_ptr + 1'b1 == hdr.len) begin
					frame_ready <= 1'b0;
					rd_ptr      <= '0;
				end
			end
		end
	end

endmodule

/* switch_fabric.sv */
`timescale 1ns/1ps
`include "switch_params.svh"

module switch_fabric import eth_types_pkg::*, fabric_types_pkg::*; (
	input  logic           clk_fabric,
	input  logic           arst_n,
	input  portmask_t      frame_ready,
	input  frame_hdr_t     hdr [`NUM_PORTS],
	input  byte_t          pop_data [`NUM_PORTS],
	input  lookup_resp_t   resp,
	output portmask_t      pop,
	output lookup_req_t    req,
	output egress_stream_t egress
);

	typedef enum logic [1:0] {IDLE, LOOKUP, FORWARD} fab_state_t;

	fab_state_t state;
	// Highest priority port for the next grant
	port_t      rr_ptr;
	// Port being served
	port_t      sel;
	port_t      grant_port;
	logic       grant_valid;
	portmask_t  src_bit;
	portmask_t  next_mask;
	portmask_t  mask_q;
	frame_len_t pop_cnt;
	logic       last_pop;
	// Output flags, one cycle behind the pops
	logic       out_valid;
	logic       out_sof;
	logic       out_eof;

	////////////////////////////////////////////////////////////
	// Round-robin arbiter

	always_comb begin
		grant_valid = 1'b0;
		grant_port  = rr_ptr;
		// Walk backwards so the nearest ready port wins
		for (int i = `NUM_PORTS - 1; i >= 0; i--) begin
			if (frame_ready[rr_ptr + port_t'(i)]) begin
				grant_valid = 1'b1;
				grant_port  = rr_ptr + port_t'(i);
			end
		end
	end

	// Learn and lookup issued with the grant
	always_comb begin
		req.en       = (state == IDLE) && grant_valid;
		req.src_mac  = hdr[grant_port].src;
		req.src_port = grant_port;
		req.dst_mac  = hdr[grant_port].dst;
	end

	////////////////////////////////////////////////////////////
	// Forwarding decision

	always_comb begin
		src_bit = portmask_t'(1) << sel;
		// Broadcast or unknown, flood all but ingress
		if (&hdr[sel].dst || !resp.hit)
			next_mask = ~src_bit;
		// Destination sits behind ingress port, filter
		else if (resp.dst_port == sel)
			next_mask = '0;
		else
			next_mask = portmask_t'(1) << resp.dst_port;
	end

	assign last_pop = (pop_cnt == hdr[sel].len - 1'b1);
	// One pop per FORWARD cycle
	assign pop      = (state == FORWARD) ? src_bit : '0;

	////////////////////////////////////////////////////////////
	// FSM

	always_ff @(posedge clk_fabric or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			rr_ptr    <= '0;
			sel       <= '0;
			mask_q    <= '0;
			pop_cnt   <= '0;
			out_valid <= 1'b0;
			out_sof   <= 1'b0;
			out_eof   <= 1'b0;
		end else begin
			// Filtered frames drain with valid held low
			out_valid <= (state == FORWARD) && (|mask_q);
			out_sof   <= (state == FORWARD) && (pop_cnt == '0);
			out_eof   <= (state == FORWARD) && last_pop;
			case (state)
				IDLE: begin
					if (grant_valid) begin
						sel    <= grant_port;
						rr_ptr <= grant_port + 1'b1;
						state  <= LOOKUP;
					end
				end
				// Response is valid in this cycle
				LOOKUP: begin
					mask_q  <= next_mask;
					pop_cnt <= '0;
					state   <= FORWARD;
				end
				FORWARD: begin
					pop_cnt <= pop_cnt + 1'b1;
					if (last_pop)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data comes straight from the selected buffer register
	assign egress = '{valid: out_valid, sof: out_sof, eof: out_eof,
		data: pop_data[sel], mask: mask_q};

endmodule

/* switch_params.svh */
`ifndef SWITCH_PARAMS_SVH
`define SWITCH_PARAMS_SVH

// Switch geometry

// Number of switch ports
`define NUM_PORTS 4

// Width of a port index
`define PORT_BITS 2

// Capacity of one input buffer in bytes
`define FRAME_BUF_BYTES 64

// Shortest accepted frame, one full Ethernet header
`define MIN_FRAME_BYTES 14

// MAC table index width, 16 entries
`define MAC_TABLE_BITS 4

`endif

/* switch_top.sv */
`timescale 1ns/1ps
`include "switch_params.svh"

module switch_top import eth_types_pkg::*, fabric_types_pkg::*; (
	input  logic         clk_fabric,
	input  logic         arst_n,
	input  rx_stream_t   rx [`NUM_PORTS],
	output portmask_t    tx_valid,
	output portmask_t    tx_sof,
	output portmask_t    tx_eof,
	output byte_t        tx_data,
	output frame_count_t tx_frame_count [`NUM_PORTS]
);

	// Buffer to fabric
	portmask_t      frame_ready;
	portmask_t      pop;
	frame_hdr_t     hdr [`NUM_PORTS];
	byte_t          pop_data [`NUM_PORTS];
	// Fabric to table
	lookup_req_t    lookup_req;
	lookup_resp_t   lookup_resp;
	// Fabric to output side
	egress_stream_t egress;

	////////////////////////////////////////////////////////////
	// Input buffers

	for (genvar g = 0; g < `NUM_PORTS; g++) begin : g_rx
		rx_frame_buffer u_rx_buf (
			.clk_fabric  (clk_fabric),
			.arst_n      (arst_n),
			.rx          (rx[g]),
			.pop         (pop[g]),
			.frame_ready (frame_ready[g]),
			.hdr         (hdr[g]),
			.pop_data    (pop_data[g])
		);
	end

	////////////////////////////////////////////////////////////
	// Fabric and MAC table

	switch_fabric u_fabric (
		.clk_fabric  (clk_fabric),
		.arst_n      (arst_n),
		.frame_ready (frame_ready),
		.hdr         (hdr),
		.pop_data    (pop_data),
		.resp        (lookup_resp),
		.pop         (pop),
		.req         (lookup_req),
		.egress      (egress)
	);

	mac_address_table u_mac_table (
		.clk_fabric (clk_fabric),
		.arst_n     (arst_n),
		.req        (lookup_req),
		.resp       (lookup_resp)
	);

	////////////////////////////////////////////////////////////
	// Output side

	tx_port_fanout u_fanout (
		.clk_fabric     (clk_fabric),
		.arst_n         (arst_n),
		.egress         (egress),
		.tx_valid       (tx_valid),
		.tx_sof         (tx_sof),
		.tx_eof         (tx_eof),
		.tx_data        (tx_data),
		.tx_frame_count (tx_frame_count)
	);

endmodule

/* tb_switch_top.sv */
`timescale 1ns/1ps
`include "switch_params.svh"

module tb_switch_top import eth_types_pkg::*, fabric_types_pkg::*; ();

	localparam int NP          = `NUM_PORTS;
	localparam int TBL_ENTRIES = 1 << `MAC_TABLE_BITS;
	localparam int MAX_LEN     = `FRAME_BUF_BYTES + 8;
	// Stations used by the directed tests
	localparam macaddr_t BCAST   = '1;
	localparam macaddr_t MAC_UNK = 48'h0200_0000_00a3;
	localparam macaddr_t MAC_A   = 48'h0200_0000_00a2;
	localparam macaddr_t MAC_B   = 48'h0200_0000_0011;
	localparam macaddr_t MAC_C   = 48'h0200_0000_00c0;
	localparam macaddr_t MAC_D   = 48'h0200_0000_00d4;
	localparam macaddr_t MAC_E   = 48'h0200_0000_00e5;

	logic         clk_fabric;
	logic         arst_n;
	rx_stream_t   rx [`NUM_PORTS];
	portmask_t    tx_valid;
	portmask_t    tx_sof;
	portmask_t    tx_eof;
	byte_t        tx_data;
	frame_count_t tx_frame_count [`NUM_PORTS];

	string        cur_test;
	// Frame under construction for each ingress port
	byte_t        frm [`NUM_PORTS][MAX_LEN];
	int           frm_len [`NUM_PORTS];
	// Shadow MAC table
	logic         tbl_valid [TBL_ENTRIES];
	macaddr_t     tbl_mac [TBL_ENTRIES];
	port_t        tbl_port [TBL_ENTRIES];
	// Expected and received traffic per egress port
	byte_t        exp_q [`NUM_PORTS][$];
	int           exp_len [`NUM_PORTS][$];
	int           exp_cnt [`NUM_PORTS];
	byte_t        rcv_q [`NUM_PORTS][$];

	initial clk_fabric = 1'b0;
	always #10 clk_fabric = ~clk_fabric;

	switch_top dut0 (
		.clk_fabric     (clk_fabric),
		.arst_n         (arst_n),
		.rx             (rx),
		.tx_valid       (tx_valid),
		.tx_sof         (tx_sof),
		.tx_eof         (tx_eof),
		.tx_data        (tx_data),
		.tx_frame_count (tx_frame_count)
	);

	////////////////////////////////////////////////////////////
	// Error reporting

	task automatic raise_error(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] expv,
		input logic [63:0] actv);
		raise_error($sformatf("MISMATCH %s: %s expected %0h actual %0h",
			cur_test, what, expv, actv));
	endtask

	////////////////////////////////////////////////////////////
	// Reference model

	// Forwarding rules of the fabric with the table read before learning
	task automatic predict_frame(input int p, input macaddr_t dst, input macaddr_t src,
		input int len);
		logic [`MAC_TABLE_BITS-1:0] di;
		logic [`MAC_TABLE_BITS-1:0] si;
		logic                       hit;
		portmask_t                  mask;
		di = dst[`MAC_TABLE_BITS-1:0];
		si = src[`MAC_TABLE_BITS-1:0];
		// Runts and oversize frames never reach the fabric
		if (len >= `MIN_FRAME_BYTES && len <= `FRAME_BUF_BYTES) begin
			hit = tbl_valid[di] && (tbl_mac[di] == dst);
			if (&dst || !hit)
				mask = ~(portmask_t'(1) << p);
			else if (tbl_port[di] == port_t'(p))
				mask = '0;
			else
				mask = portmask_t'(1) << tbl_port[di];
			tbl_valid[si] = 1'b1;
			tbl_mac[si]   = src;
			tbl_port[si]  = port_t'(p);
			for (int q = 0; q < NP; q++) begin
				if (mask[q]) begin
					exp_len[q].push_back(len);
					exp_cnt[q]++;
					for (int i = 0; i < len; i++)
						exp_q[q].push_back(frm[p][i]);
				end
			end
		end
	endtask

	// Header bytes most significant first and then random payload
	task automatic build_frame(input int p, input macaddr_t dst, input macaddr_t src,
		input int len);
		for (int i = 0; i < MAX_LEN; i++)
			frm[p][i] = byte_t'($urandom);
		for (int i = 0; i < 6; i++) begin
			frm[p][i]     = dst[8*(5-i) +: 8];
			frm[p][6 + i] = src[8*(5-i) +: 8];
		end
		frm_len[p] = len;
		predict_frame(p, dst, src, len);
	endtask

	function automatic macaddr_t burst_mac(input int p);
		// Table slots 8 to 11 stay clear of the earlier stations
		return 48'h0200_0000_5008 + macaddr_t'(p);
	endfunction

	function automatic int random_len();
		return `MIN_FRAME_BYTES +
			int'($urandom % (`FRAME_BUF_BYTES - `MIN_FRAME_BYTES + 1));
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus and waits

	// All selected ports start in the same cycle
	task automatic drive_frames(input portmask_t ports);
		int longest;
		longest = 0;
		for (int p = 0; p < NP; p++)
			if (ports[p] && frm_len[p] > longest)
				longest = frm_len[p];
		for (int i = 0; i < longest; i++) begin
			@(posedge clk_fabric);
			for (int p = 0; p < NP; p++) begin
				if (ports[p] && i < frm_len[p])
					rx[p] <= '{valid: 1'b1, sof: i == 0, eof: i == frm_len[p] - 1,
						data: frm[p][i]};
				else
					rx[p] <= '0;
			end
		end
		@(posedge clk_fabric);
		for (int p = 0; p < NP; p++)
			rx[p] <= '0;
	endtask

	task automatic wait_drain();
		int   cycles;
		logic busy;
		cycles = 0;
		busy   = 1'b1;
		while (busy) begin
			@(posedge clk_fabric);
			busy = 1'b0;
			for (int q = 0; q < NP; q++)
				if (exp_len[q].size() != 0)
					busy = 1'b1;
			cycles++;
			if (busy && cycles > 1000)
				raise_error($sformatf("%s: timed out waiting for the expected frames",
					cur_test));
		end
	endtask

	task automatic check_counts();
		@(negedge clk_fabric);
		for (int q = 0; q < NP; q++)
			assert (tx_frame_count[q] == frame_count_t'(exp_cnt[q])) else
				report_mismatch($sformatf("frame count port %0d", q),
					64'(exp_cnt[q]), 64'(tx_frame_count[q]));
	endtask

	////////////////////////////////////////////////////////////
	// Monitor

	task automatic compare_frame(input int q);
		int    elen;
		byte_t eb;
		assert (exp_len[q].size() != 0) else
			raise_error($sformatf("%s: port %0d sent a frame that was not expected",
				cur_test, q));
		elen = exp_len[q].pop_front();
		assert (rcv_q[q].size() == elen) else
			report_mismatch($sformatf("length port %0d", q), 64'(elen),
				64'(rcv_q[q].size()));
		for (int i = 0; i < elen; i++) begin
			eb = exp_q[q].pop_front();
			assert (rcv_q[q][i] == eb) else
				report_mismatch($sformatf("byte %0d port %0d", i, q), 64'(eb),
					64'(rcv_q[q][i]));
		end
		rcv_q[q].delete();
	endtask

	// Registered outputs are stable on the falling edge
	always @(negedge clk_fabric) begin
		if (arst_n) begin
			for (int q = 0; q < NP; q++) begin
				if (tx_valid[q]) begin
					assert (tx_sof[q] == (rcv_q[q].size() == 0)) else
						report_mismatch($sformatf("sof port %0d", q),
							64'(rcv_q[q].size() == 0), 64'(tx_sof[q]));
					rcv_q[q].push_back(tx_data);
					if (tx_eof[q])
						compare_frame(q);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic flood_unknown_unicast();
		cur_test = "flood_unknown_unicast";
		build_frame(1, MAC_UNK, MAC_B, 20);
		drive_frames(4'b0010);
		wait_drain();
		check_counts();
	endtask

	task automatic learn_and_forward();
		cur_test = "learn_and_forward";
		build_frame(2, MAC_UNK, MAC_A, 16);
		drive_frames(4'b0100);
		wait_drain();
		// A now sits behind port 2
		build_frame(0, MAC_A, MAC_C, 30);
		drive_frames(4'b0001);
		wait_drain();
		check_counts();
	endtask

	task automatic broadcast_after_learning();
		cur_test = "broadcast_after_learning";
		// All ones as a source fills its slot
		build_frame(0, MAC_UNK, BCAST, 18);
		drive_frames(4'b0001);
		wait_drain();
		build_frame(3, BCAST, MAC_D, 24);
		drive_frames(4'b1000);
		wait_drain();
		check_counts();
	endtask

	task automatic drop_and_filter();
		cur_test = "drop_and_filter";
		build_frame(1, BCAST, MAC_B, 10);
		drive_frames(4'b0010);
		build_frame(1, BCAST, MAC_B, 70);
		drive_frames(4'b0010);
		// A was learned on port 2
		build_frame(2, MAC_A, MAC_E, 20);
		drive_frames(4'b0100);
		// Marker frame is served after the filtered one
		build_frame(3, BCAST, MAC_D, 16);
		drive_frames(4'b1000);
		wait_drain();
		check_counts();
	endtask

	task automatic random_burst();
		cur_test = "random_burst";
		// Teach one station per port with one frame at a time
		for (int p = 0; p < NP; p++) begin
			build_frame(p, BCAST, burst_mac(p), random_len());
			drive_frames(portmask_t'(1) << p);
			wait_drain();
		end
		// Each port sends to its neighbour so every egress port gets one frame
		for (int p = 0; p < NP; p++)
			build_frame(p, burst_mac((p + 1) % NP), burst_mac(p), random_len());
		drive_frames('1);
		wait_drain();
		check_counts();
	endtask

	initial begin
		void'($urandom(32'h96719d39));
		arst_n <= 1'b0;
		for (int p = 0; p < NP; p++) begin
			rx[p]      <= '0;
			exp_cnt[p] = 0;
		end
		for (int i = 0; i < TBL_ENTRIES; i++)
			tbl_valid[i] = 1'b0;
		cur_test = "reset";
		repeat (3) @(posedge clk_fabric);
		arst_n <= 1'b1;
		@(posedge clk_fabric);
		check_counts();
		flood_unknown_unicast();
		learn_and_forward();
		broadcast_after_learning();
		drop_and_filter();
		random_burst();
		$display(">>> PASS");
		$finish;
	end

endmodule

/* tx_port_fanout.sv */
`timescale 1ns/1ps
`include "switch_params.svh"

module tx_port_fanout import eth_types_pkg::*, fabric_types_pkg::*; (
	input  logic           clk_fabric,
	input  logic           arst_n,
	input  egress_stream_t egress,
	output portmask_t      tx_valid,
	output portmask_t      tx_sof,
	output portmask_t      tx_eof,
	output byte_t          tx_data,
	output frame_count_t   tx_frame_count [`NUM_PORTS]
);

	// Ports that get the current byte
	portmask_t port_sel;

	assign port_sel = egress.valid ? egress.mask : '0;

	////////////////////////////////////////////////////////////
	// Per port strobes and counters

	always_ff @(posedge clk_fabric or negedge arst_n) begin
		if (!arst_n) begin
			tx_valid <= '0;
			tx_sof   <= '0;
			tx_eof   <= '0;
			for (int p = 0; p < `NUM_PORTS; p++)
				tx_frame_count[p] <= '0;
		end else begin
			tx_valid <= port_sel;
			tx_sof   <= egress.sof ? port_sel : '0;
			tx_eof   <= egress.eof ? port_sel : '0;
			// Count moves together with the outgoing eof
			for (int p = 0; p < `NUM_PORTS; p++) begin
				if (egress.eof && port_sel[p])
					tx_frame_count[p] <= tx_frame_count[p] + 1'b1;
			end
		end
	end

	// Shared data bus, qualified by tx_valid
	always_ff @(posedge clk_fabric)
		tx_data <= egress.data;

endmodule
